/* rv_ops_pkg.sv */
package rv_ops_pkg;

  // RV32 data and address width.
  localparam int xlen = 32;

  typedef enum logic [2:0] {
    op_alu,
    op_lui,
    op_auipc,
    op_load,
    op_store
  } op_kind_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu
  } alu_op_t;

  // Width and sign of a memory access.
  typedef enum logic [2:0] {
    lsu_lb,
    lsu_lbu,
    lsu_lh,
    lsu_lhu,
    lsu_lw,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_t;

endpackage

/* mem_pkg.sv */
package mem_pkg;

  // One enable per byte lane of a word.
  localparam int be_width = 4;

  typedef enum logic [1:0] {
    mem_idle,
    mem_wait,
    mem_done
  } mem_state_t;

endpackage

/* alu.sv */
module alu (
  input  logic [rv_ops_pkg::xlen-1:0] a,
  input  logic [rv_ops_pkg::xlen-1:0] b,
  input  rv_ops_pkg::alu_op_t         op,
  output logic [rv_ops_pkg::xlen-1:0] res
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      rv_ops_pkg::alu_add:  res = a + b;
      rv_ops_pkg::alu_sub:  res = a - b;
      rv_ops_pkg::alu_and:  res = a & b;
      rv_ops_pkg::alu_or:   res = a | b;
      rv_ops_pkg::alu_xor:  res = a ^ b;
      rv_ops_pkg::alu_sll:  res = a << shamt;
      rv_ops_pkg::alu_srl:  res = a >> shamt;
      rv_ops_pkg::alu_sra:  res = $signed(a) >>> shamt;
      // Compare results are a single bit in the LSB.
      rv_ops_pkg::alu_slt:  res = {{(rv_ops_pkg::xlen-1){1'b0}}, lt_s};
      rv_ops_pkg::alu_sltu: res = {{(rv_ops_pkg::xlen-1){1'b0}}, lt_u};
      default:              res = '0;
    endcase
  end

endmodule

/* lsu.sv */
module lsu (
  input  logic [rv_ops_pkg::xlen-1:0]     addr,
  input  rv_ops_pkg::lsu_op_t             op,
  input  logic [rv_ops_pkg::xlen-1:0]     sdata,
  input  logic [rv_ops_pkg::xlen-1:0]     rdata,
  output logic [mem_pkg::be_width-1:0]    be,
  output logic [rv_ops_pkg::xlen-1:0]     wdata,
  output logic [rv_ops_pkg::xlen-1:0]     ldata
);

  logic [rv_ops_pkg::xlen-1:0] shifted;

  // Bring the addressed byte or halfword down to bit 0.
  assign shifted = rdata >> {addr[1:0], 3'b000};

  //////////////////////////////
  // Store lanes
  //////////////////////////////

  always_comb begin
    be    = '0;
    wdata = sdata;
    case (op)
      rv_ops_pkg::lsu_sb: begin
        be    = 4'b0001 << addr[1:0];
        wdata = {4{sdata[7:0]}};
      end
      rv_ops_pkg::lsu_sh: begin
        be    = addr[1] ? 4'b1100 : 4'b0011;
        wdata = {2{sdata[15:0]}};
      end
      rv_ops_pkg::lsu_sw: be = 4'b1111;
      default: be = '0;
    endcase
  end

  //////////////////////////////
  // Load extraction
  //////////////////////////////

  always_comb begin
    case (op)
      rv_ops_pkg::lsu_lb:  ldata = {{24{shifted[7]}}, shifted[7:0]};
      rv_ops_pkg::lsu_lbu: ldata = {24'b0, shifted[7:0]};
      rv_ops_pkg::lsu_lh:  ldata = {{16{shifted[15]}}, shifted[15:0]};
      rv_ops_pkg::lsu_lhu: ldata = {16'b0, shifted[15:0]};
      default:             ldata = rdata;
    endcase
  end

endmodule

/* mem_fsm.sv */
module mem_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic expired,
  output logic load_timer,
  output logic mem_ready
);

  mem_pkg::mem_state_t state;
  mem_pkg::mem_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      mem_pkg::mem_idle: begin
        if (start) begin
          state_next = mem_pkg::mem_wait;
        end
      end
      mem_pkg::mem_wait: begin
        if (expired) begin
          state_next = mem_pkg::mem_done;
        end
      end
      // Done lasts a single cycle.
      mem_pkg::mem_done: state_next = mem_pkg::mem_idle;
      default:           state_next = mem_pkg::mem_idle;
    endcase
  end

  // Timer is armed on the same edge that enters the wait state.
  assign load_timer = (state == mem_pkg::mem_idle) && start;
  assign mem_ready  = (state == mem_pkg::mem_done);

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      state <= mem_pkg::mem_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* wait_timer.sv */
module wait_timer #(
  parameter int WAIT_CYCLES = 2
) (
  input  logic clk,
  input  logic rst,
  input  logic load_timer,
  output logic expired
);

  // At least one wait cycle, so the access always completes.
  localparam int LOAD_VAL = (WAIT_CYCLES < 1) ? 1 : WAIT_CYCLES;
  localparam int CW       = $clog2(LOAD_VAL + 1);

  logic [CW-1:0] count;

  assign expired = (count == CW'(1));

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      count <= '0;
    end else if (load_timer) begin
      count <= CW'(LOAD_VAL);
    end else if (count != '0) begin
      count <= count - CW'(1);
    end
  end

endmodule

/* data_ram.sv */
module data_ram #(
  parameter int MEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_ops_pkg::xlen-1:0]   addr,
  input  logic [mem_pkg::be_width-1:0]  be,
  input  logic [rv_ops_pkg::xlen-1:0]   wdata,
  input  logic                          we,
  output logic [rv_ops_pkg::xlen-1:0]   rdata
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [rv_ops_pkg::xlen-1:0] mem [MEM_WORDS];
  logic [AW-1:0]               word;

  // Byte address to word index.
  assign word  = addr[AW+1:2];
  assign rdata = mem[word];

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      for (int j = 0; j < mem_pkg::be_width; j++) begin
        if (be[j]) begin
          mem[word][8*j +: 8] <= wdata[8*j +: 8];
        end
      end
    end
  end

endmodule

/* execute_stage.sv */
module execute_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        issue,
  input  rv_ops_pkg::op_kind_t        kind,
  input  rv_ops_pkg::alu_op_t         alu_op,
  input  rv_ops_pkg::lsu_op_t         lsu_op,
  input  logic [rv_ops_pkg::xlen-1:0] pc,
  input  logic [rv_ops_pkg::xlen-1:0] imm,
  input  logic [rv_ops_pkg::xlen-1:0] rdata1,
  input  logic [rv_ops_pkg::xlen-1:0] rdata2,
  input  logic                        use_imm,
  input  logic [4:0]                  waddr,
  input  logic                        clear,
  output logic [rv_ops_pkg::xlen-1:0] a,
  output logic [rv_ops_pkg::xlen-1:0] b,
  output rv_ops_pkg::alu_op_t         alu_op_q,
  output logic [rv_ops_pkg::xlen-1:0] addr_op,
  output rv_ops_pkg::lsu_op_t         lsu_op_q,
  output logic [rv_ops_pkg::xlen-1:0] sdata,
  output logic                        start,
  output logic                        is_store,
  output logic                        busy,
  input  logic [rv_ops_pkg::xlen-1:0] alu_res,
  input  logic [rv_ops_pkg::xlen-1:0] ldata,
  input  logic                        mem_ready,
  output logic                        wb_wren,
  output logic [4:0]                  wb_waddr,
  output logic [rv_ops_pkg::xlen-1:0] wb_wdata
);

  rv_ops_pkg::op_kind_t        kind_q;
  logic [rv_ops_pkg::xlen-1:0] pc_q;
  logic [rv_ops_pkg::xlen-1:0] imm_q;
  logic [rv_ops_pkg::xlen-1:0] rdata1_q;
  logic [rv_ops_pkg::xlen-1:0] rdata2_q;
  logic                        use_imm_q;
  logic [4:0]                  waddr_q;
  logic                        wren_q;
  logic                        ld_done_q;
  logic                        cap;
  logic                        mem_op;

  assign cap    = issue && !busy;
  assign mem_op = (kind == rv_ops_pkg::op_load) || (kind == rv_ops_pkg::op_store);

  //////////////////////////////
  // Operands to the units
  //////////////////////////////

  assign a        = rdata1_q;
  assign b        = use_imm_q ? imm_q : rdata2_q;
  assign addr_op  = rdata1_q + imm_q;
  assign sdata    = rdata2_q;
  assign is_store = busy && (kind_q == rv_ops_pkg::op_store);

  // Result select. A finished load takes priority.
  always_comb begin
    if (ld_done_q) begin
      wb_wdata = ldata;
    end else begin
      case (kind_q)
        rv_ops_pkg::op_lui:   wb_wdata = imm_q;
        rv_ops_pkg::op_auipc: wb_wdata = pc_q + imm_q;
        default:              wb_wdata = alu_res;
      endcase
    end
  end

  assign wb_wren  = wren_q || ld_done_q;
  assign wb_waddr = waddr_q;

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (cap) begin
      alu_op_q  <= alu_op;
      lsu_op_q  <= lsu_op;
      pc_q      <= pc;
      imm_q     <= imm;
      rdata1_q  <= rdata1;
      rdata2_q  <= rdata2;
      use_imm_q <= use_imm;
      waddr_q   <= waddr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      kind_q    <= rv_ops_pkg::op_alu;
      wren_q    <= 1'b0;
      start     <= 1'b0;
      busy      <= 1'b0;
      ld_done_q <= 1'b0;
    end else begin
      // Killed operations become a bubble.
      if (cap) begin
        kind_q <= clear ? rv_ops_pkg::op_alu : kind;
      end
      wren_q <= cap && !clear && !mem_op;
      start  <= cap && !clear && mem_op;
      if (cap && !clear && mem_op) begin
        busy <= 1'b1;
      end else if (mem_ready) begin
        busy <= 1'b0;
      end
      // x0 loads finish without a write.
      ld_done_q <= mem_ready && (kind_q == rv_ops_pkg::op_load) && (waddr_q != 5'd0);
    end
  end

endmodule

/* exec_top.sv */
module exec_top #(
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        issue,
  input  rv_ops_pkg::op_kind_t        kind,
  input  rv_ops_pkg::alu_op_t         alu_op,
  input  rv_ops_pkg::lsu_op_t         lsu_op,
  input  logic [rv_ops_pkg::xlen-1:0] pc,
  input  logic [rv_ops_pkg::xlen-1:0] imm,
  input  logic [rv_ops_pkg::xlen-1:0] rdata1,
  input  logic [rv_ops_pkg::xlen-1:0] rdata2,
  input  logic                        use_imm,
  input  logic [4:0]                  waddr,
  input  logic                        clear,
  output logic                        busy,
  output logic                        wb_wren,
  output logic [4:0]                  wb_waddr,
  output logic [rv_ops_pkg::xlen-1:0] wb_wdata
);

  logic [rv_ops_pkg::xlen-1:0]    a;
  logic [rv_ops_pkg::xlen-1:0]    b;
  logic [rv_ops_pkg::xlen-1:0]    alu_res;
  rv_ops_pkg::alu_op_t            alu_op_q;
  rv_ops_pkg::lsu_op_t            lsu_op_q;
  logic [rv_ops_pkg::xlen-1:0]    addr_op;
  logic [rv_ops_pkg::xlen-1:0]    sdata;
  logic [rv_ops_pkg::xlen-1:0]    ldata;
  logic [rv_ops_pkg::xlen-1:0]    wdata;
  logic [rv_ops_pkg::xlen-1:0]    rdata;
  logic [mem_pkg::be_width-1:0]   be;
  logic                           start;
  logic                           is_store;
  logic                           load_timer;
  logic                           expired;
  logic                           mem_ready;
  logic                           we;

  // Write happens in the single done cycle.
  assign we = mem_ready && is_store;

  execute_stage execute_stage_inst (
    .clk(clk), .rst(rst), .issue(issue), .kind(kind), .alu_op(alu_op),
    .lsu_op(lsu_op), .pc(pc), .imm(imm), .rdata1(rdata1), .rdata2(rdata2),
    .use_imm(use_imm), .waddr(waddr), .clear(clear), .a(a), .b(b),
    .alu_op_q(alu_op_q), .addr_op(addr_op), .lsu_op_q(lsu_op_q), .sdata(sdata),
    .start(start), .is_store(is_store), .busy(busy), .alu_res(alu_res),
    .ldata(ldata), .mem_ready(mem_ready), .wb_wren(wb_wren),
    .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
  );

  alu alu_inst (.a(a), .b(b), .op(alu_op_q), .res(alu_res));

  lsu lsu_inst (
    .addr(addr_op), .op(lsu_op_q), .sdata(sdata), .rdata(rdata),
    .be(be), .wdata(wdata), .ldata(ldata)
  );

  mem_fsm mem_fsm_inst (
    .clk(clk), .rst(rst), .start(start), .expired(expired),
    .load_timer(load_timer), .mem_ready(mem_ready)
  );

  wait_timer #(.WAIT_CYCLES(WAIT_CYCLES)) wait_timer_inst (
    .clk(clk), .rst(rst), .load_timer(load_timer), .expired(expired)
  );

  data_ram #(.MEM_WORDS(MEM_WORDS)) data_ram_inst (
    .clk(clk), .rst(rst), .addr(addr_op), .be(be), .wdata(wdata),
    .we(we), .rdata(rdata)
  );

endmodule

/* exec_assertions.sv */
module exec_assertions (
  input logic                clk,
  input logic                rst,
  input logic                busy,
  input logic                wb_wren,
  input logic                start,
  input logic                mem_ready,
  input mem_pkg::mem_state_t fsm_state
);

  // A load write-back only leaves once the access has let go of busy.
  wb_not_busy: assert property (@(posedge clk) disable iff (rst == 0) wb_wren |-> !busy)
    else $error("wb_wren is high while busy is high");

  start_pulse: assert property (@(posedge clk) disable iff (rst == 0) start |=> !start)
    else $error("start stayed high for more than one cycle");

  // Done only follows a wait, with the stage still stalled.
  ready_state: assert property (@(posedge clk) disable iff (rst == 0)
    mem_ready |-> busy && ($past(fsm_state) == mem_pkg::mem_wait))
    else $error("mem_ready is high outside a memory access");

endmodule

bind exec_top exec_assertions exec_assertions_inst (
  .clk(clk), .rst(rst), .busy(busy), .wb_wren(wb_wren), .start(start),
  .mem_ready(mem_ready), .fsm_state(mem_fsm_inst.state)
);

/* exec_checker.sv */
module exec_checker #(
  parameter int MEM_WORDS   = 64,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        issue,
  input  rv_ops_pkg::op_kind_t        kind,
  input  rv_ops_pkg::alu_op_t         alu_op,
  input  rv_ops_pkg::lsu_op_t         lsu_op,
  input  logic [rv_ops_pkg::xlen-1:0] pc,
  input  logic [rv_ops_pkg::xlen-1:0] imm,
  input  logic [rv_ops_pkg::xlen-1:0] rdata1,
  input  logic [rv_ops_pkg::xlen-1:0] rdata2,
  input  logic                        use_imm,
  input  logic [4:0]                  waddr,
  input  logic                        clear,
  input  logic                        busy,
  input  logic                        wb_wren,
  input  logic [4:0]                  wb_waddr,
  input  logic [rv_ops_pkg::xlen-1:0] wb_wdata,
  output int                          mismatch_count,
  output int                          unexpected_count,
  output int                          missing_count,
  output int                          pending_count
);

  logic [31:0] model [MEM_WORDS];
  logic [31:0] exp_data [$];
  logic [4:0]  exp_waddr [$];
  int          exp_cycle [$];
  logic [31:0] addr_v;
  int          idx;
  int          cycle = 0;
  int          busy_left = 0;
  int          mismatches = 0;
  int          unexpected = 0;
  int          missing = 0;
  int          pending = 0;

  assign mismatch_count   = mismatches;
  assign unexpected_count = unexpected;
  assign missing_count    = missing;
  assign pending_count    = pending;

  // Expected write-back value by the RV32I rules.
  function automatic logic [31:0] ref_result(
    input rv_ops_pkg::op_kind_t k,
    input rv_ops_pkg::alu_op_t  op,
    input rv_ops_pkg::lsu_op_t  lop,
    input logic [31:0]          pc_v,
    input logic [31:0]          imm_v,
    input logic [31:0]          r1,
    input logic [31:0]          r2,
    input logic                 ui,
    input logic [31:0]          word
  );
    logic [31:0] b_v;
    logic [31:0] ea;
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    logic [31:0] res;
    b_v    = ui ? imm_v : r2;
    ea     = r1 + imm_v;
    byte_v = word[{ea[1:0], 3'b000} +: 8];
    half_v = ea[1] ? word[31:16] : word[15:0];
    case (k)
      rv_ops_pkg::op_lui:   res = imm_v;
      rv_ops_pkg::op_auipc: res = pc_v + imm_v;
      rv_ops_pkg::op_load: begin
        case (lop)
          rv_ops_pkg::lsu_lb:  res = {{24{byte_v[7]}}, byte_v};
          rv_ops_pkg::lsu_lbu: res = {24'h0, byte_v};
          rv_ops_pkg::lsu_lh:  res = {{16{half_v[15]}}, half_v};
          rv_ops_pkg::lsu_lhu: res = {16'h0, half_v};
          default:             res = word;
        endcase
      end
      default: begin
        case (op)
          rv_ops_pkg::alu_add:  res = r1 + b_v;
          rv_ops_pkg::alu_sub:  res = r1 - b_v;
          rv_ops_pkg::alu_and:  res = r1 & b_v;
          rv_ops_pkg::alu_or:   res = r1 | b_v;
          rv_ops_pkg::alu_xor:  res = r1 ^ b_v;
          rv_ops_pkg::alu_sll:  res = r1 << b_v[4:0];
          rv_ops_pkg::alu_srl:  res = r1 >> b_v[4:0];
          rv_ops_pkg::alu_sra:  res = $signed(r1) >>> b_v[4:0];
          rv_ops_pkg::alu_slt:  res = {31'h0, $signed(r1) < $signed(b_v)};
          default:              res = {31'h0, r1 < b_v};
        endcase
      end
    endcase
    return res;
  endfunction

  // Byte-enable rule for stores.
  function automatic logic [31:0] store_merge(
    input logic [31:0]         word,
    input rv_ops_pkg::lsu_op_t lop,
    input logic [1:0]          off,
    input logic [31:0]         data
  );
    logic [31:0] res;
    res = word;
    case (lop)
      rv_ops_pkg::lsu_sb: res[{off, 3'b000} +: 8] = data[7:0];
      rv_ops_pkg::lsu_sh: begin
        if (off[1]) begin
          res[31:16] = data[15:0];
        end else begin
          res[15:0] = data[15:0];
        end
      end
      default: res = data;
    endcase
    return res;
  endfunction

  always @(negedge clk) begin
    cycle++;
    if (rst == 0) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        model[i] = '0;
      end
      exp_data.delete();
      exp_waddr.delete();
      exp_cycle.delete();
      busy_left = 0;
    end else begin
      ////////////////////////////////
      // Compare busy
      ////////////////////////////////
      if (busy !== (busy_left > 0)) begin
        $display("[ERROR] busy expected %h got %h", busy_left > 0, busy);
        mismatches++;
      end
      if (busy_left > 0) begin
        busy_left--;
      end
      ////////////////////////////////
      // Compare write-backs
      ////////////////////////////////
      if (wb_wren) begin
        if (exp_data.size() == 0) begin
          $display("Write-back to x%0d arrived with no operation expecting it", wb_waddr);
          unexpected++;
        end else begin
          if (cycle != exp_cycle[0]) begin
            $display("Write-back to x%0d arrived in the wrong cycle", wb_waddr);
            mismatches++;
          end
          if (wb_waddr !== exp_waddr[0]) begin
            $display("[ERROR] wb_waddr expected %h got %h", exp_waddr[0], wb_waddr);
            mismatches++;
          end
          if (wb_wdata !== exp_data[0]) begin
            $display("[ERROR] wb_wdata expected %h got %h", exp_data[0], wb_wdata);
            mismatches++;
          end
          void'(exp_data.pop_front());
          void'(exp_waddr.pop_front());
          void'(exp_cycle.pop_front());
        end
      end else if (exp_data.size() != 0) begin
        if (cycle >= exp_cycle[0]) begin
          $display("Expected write-back to x%0d never arrived", exp_waddr[0]);
          missing++;
          void'(exp_data.pop_front());
          void'(exp_waddr.pop_front());
          void'(exp_cycle.pop_front());
        end
      end
      ////////////////////////////////
      // Capture at the coming edge
      ////////////////////////////////
      if (issue && !busy && !clear) begin
        addr_v = rdata1 + imm;
        idx    = int'(addr_v[31:2] % MEM_WORDS);
        // Start, wait and done cycles of a memory access.
        if (kind == rv_ops_pkg::op_load || kind == rv_ops_pkg::op_store) begin
          busy_left = WAIT_CYCLES + 2;
        end
        if (kind == rv_ops_pkg::op_store) begin
          model[idx] = store_merge(model[idx], lsu_op, addr_v[1:0], rdata2);
        end else if (kind != rv_ops_pkg::op_load || waddr != 5'd0) begin
          exp_data.push_back(ref_result(kind, alu_op, lsu_op, pc, imm, rdata1, rdata2,
                                        use_imm, model[idx]));
          exp_waddr.push_back(waddr);
          // Loads write back the cycle after the done cycle.
          exp_cycle.push_back((kind == rv_ops_pkg::op_load) ? cycle + WAIT_CYCLES + 3
                                                            : cycle + 1);
        end
      end
    end
    pending = exp_data.size();
  end

endmodule

/* exec_tb.sv */
module exec_tb;

  localparam int MEM_WORDS   = 64;
  localparam int WAIT_CYCLES = 2;
  localparam int wait_limit  = 50;

  logic                 clk;
  logic                 rst;
  logic                 issue;
  rv_ops_pkg::op_kind_t kind;
  rv_ops_pkg::alu_op_t  alu_op;
  rv_ops_pkg::lsu_op_t  lsu_op;
  logic [31:0]          pc;
  logic [31:0]          imm;
  logic [31:0]          rdata1;
  logic [31:0]          rdata2;
  logic                 use_imm;
  logic [4:0]           waddr;
  logic                 clear;
  logic                 busy;
  logic                 wb_wren;
  logic [4:0]           wb_waddr;
  logic [31:0]          wb_wdata;
  int                   seed;
  int                   timeouts;
  int                   mismatches;
  int                   unexpected;
  int                   missing;
  int                   pending;

  exec_top #(.MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) exec_top_inst (
    .clk(clk), .rst(rst), .issue(issue), .kind(kind), .alu_op(alu_op), .lsu_op(lsu_op),
    .pc(pc), .imm(imm), .rdata1(rdata1), .rdata2(rdata2), .use_imm(use_imm),
    .waddr(waddr), .clear(clear), .busy(busy), .wb_wren(wb_wren),
    .wb_waddr(wb_waddr), .wb_wdata(wb_wdata)
  );

  exec_checker #(.MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) exec_checker_inst (
    .clk(clk), .rst(rst), .issue(issue), .kind(kind), .alu_op(alu_op), .lsu_op(lsu_op),
    .pc(pc), .imm(imm), .rdata1(rdata1), .rdata2(rdata2), .use_imm(use_imm),
    .waddr(waddr), .clear(clear), .busy(busy), .wb_wren(wb_wren),
    .wb_waddr(wb_waddr), .wb_wdata(wb_wdata), .mismatch_count(mismatches),
    .unexpected_count(unexpected), .missing_count(missing), .pending_count(pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  // Random byte address inside the RAM, aligned to the access width.
  function automatic logic [31:0] align_addr(input rv_ops_pkg::lsu_op_t lop);
    logic [31:0] a;
    a = rand32() & 32'(MEM_WORDS * 4 - 1);
    case (lop)
      rv_ops_pkg::lsu_lh, rv_ops_pkg::lsu_lhu, rv_ops_pkg::lsu_sh: a[0] = 1'b0;
      rv_ops_pkg::lsu_lw, rv_ops_pkg::lsu_sw: a[1:0] = 2'b00;
      default: a = a;
    endcase
    return a;
  endfunction

  task automatic finish_run();
    $display("Errors: mismatches %0d, unexpected %0d, missing %0d, pending %0d, timeouts %0d",
             mismatches, unexpected, missing, pending, timeouts);
    if (mismatches + unexpected + missing + pending + timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < wait_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy) begin
      $display("Timeout: busy stayed high for %0d cycles", wait_limit);
      timeouts++;
    end
  endtask

  // Holds the operation until the stage takes it.
  task automatic send(input rv_ops_pkg::op_kind_t k, input rv_ops_pkg::alu_op_t aop,
                      input rv_ops_pkg::lsu_op_t lop, input logic [31:0] pc_v,
                      input logic [31:0] imm_v, input logic [31:0] r1, input logic [31:0] r2,
                      input logic ui, input logic [4:0] wa, input logic clr);
    kind    = k;
    alu_op  = aop;
    lsu_op  = lop;
    pc      = pc_v;
    imm     = imm_v;
    rdata1  = r1;
    rdata2  = r2;
    use_imm = ui;
    waddr   = wa;
    clear   = clr;
    issue   = 1'b1;
    wait_idle();
    @(posedge clk);
    #1;
    issue = 1'b0;
    clear = 1'b0;
  endtask

  task automatic mem_op(input rv_ops_pkg::op_kind_t k, input rv_ops_pkg::lsu_op_t lop,
                        input logic [31:0] addr, input logic [31:0] data,
                        input logic [4:0] wa, input logic clr);
    logic [31:0] r;
    logic [31:0] off;
    r   = rand32();
    off = {{24{r[7]}}, r[7:0]};
    send(k, rv_ops_pkg::alu_add, lop, rand32(), off, addr - off, data, 1'b0, wa, clr);
  endtask

  task automatic load_word(input logic [31:0] base);
    for (int o = 0; o < 4; o++) begin
      mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lb, base + 32'(o), 0, rand_reg(), 1'b0);
      mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lbu, base + 32'(o), 0, rand_reg(), 1'b0);
    end
    for (int o = 0; o < 4; o += 2) begin
      mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lh, base + 32'(o), 0, rand_reg(), 1'b0);
      mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lhu, base + 32'(o), 0, rand_reg(), 1'b0);
    end
    mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lw, base, 0, rand_reg(), 1'b0);
  endtask

  task automatic random_mix(input int count);
    logic [31:0]         r;
    int                  pick;
    logic                clr;
    rv_ops_pkg::lsu_op_t lop;
    for (int i = 0; i < count; i++) begin
      r    = rand32();
      pick = int'(r[7:0]) % 5;
      clr  = (r[20:16] == 5'd0);
      if (pick == 3) begin
        lop = rv_ops_pkg::lsu_op_t'(3'(int'(r[15:8]) % 5));
        mem_op(rv_ops_pkg::op_load, lop, align_addr(lop), 0, rand_reg(), clr);
      end else if (pick == 4) begin
        lop = rv_ops_pkg::lsu_op_t'(3'(5 + int'(r[15:8]) % 3));
        mem_op(rv_ops_pkg::op_store, lop, align_addr(lop), rand32(), rand_reg(), clr);
      end else begin
        send(rv_ops_pkg::op_kind_t'(3'(pick)), rv_ops_pkg::alu_op_t'(4'(int'(r[15:8]) % 10)),
             rv_ops_pkg::lsu_lw, rand32(), rand32(), rand32(), rand32(), r[17], rand_reg(), clr);
      end
    end
  endtask

  initial begin
    seed     = 32'hee90;
    timeouts = 0;
    issue    = 1'b0;
    kind     = rv_ops_pkg::op_alu;
    alu_op   = rv_ops_pkg::alu_add;
    lsu_op   = rv_ops_pkg::lsu_lw;
    pc       = '0;
    imm      = '0;
    rdata1   = '0;
    rdata2   = '0;
    use_imm  = 1'b0;
    waddr    = '0;
    clear    = 1'b0;
    rst      = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b1;

    // Every ALU op, register and immediate operand.
    for (int i = 0; i < 10; i++) begin
      for (int j = 0; j < 4; j++) begin
        send(rv_ops_pkg::op_alu, rv_ops_pkg::alu_op_t'(4'(i)), rv_ops_pkg::lsu_lw, rand32(),
             rand32(), rand32(), rand32(), j[0], rand_reg(), 1'b0);
      end
    end
    for (int i = 0; i < 4; i++) begin
      send(rv_ops_pkg::op_lui, rv_ops_pkg::alu_add, rv_ops_pkg::lsu_lw, rand32(), rand32(),
           rand32(), rand32(), 1'b0, rand_reg(), 1'b0);
      send(rv_ops_pkg::op_auipc, rv_ops_pkg::alu_add, rv_ops_pkg::lsu_lw, rand32(), rand32(),
           rand32(), rand32(), 1'b0, rand_reg(), 1'b0);
    end

    ////////////////////////////////
    // Stores of each width, then loads
    ////////////////////////////////
    mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sw, 32'h40, rand32(), rand_reg(), 1'b0);
    mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sb, 32'h41, rand32(), rand_reg(), 1'b0);
    mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sh, 32'h80, rand32(), rand_reg(), 1'b0);
    mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sh, 32'h82, rand32(), rand_reg(), 1'b0);
    for (int o = 0; o < 4; o++) begin
      mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sb, 32'hc0 + 32'(o), rand32(), rand_reg(),
             1'b0);
    end
    load_word(32'h40);
    load_word(32'h80);
    load_word(32'hc0);

    // Load to x0 writes nothing.
    mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lw, 32'h40, 0, 5'd0, 1'b0);

    // Cleared operations leave no trace.
    mem_op(rv_ops_pkg::op_store, rv_ops_pkg::lsu_sw, 32'h40, rand32(), rand_reg(), 1'b1);
    mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lw, 32'h80, 0, rand_reg(), 1'b1);
    send(rv_ops_pkg::op_alu, rv_ops_pkg::alu_add, rv_ops_pkg::lsu_lw, rand32(), rand32(),
         rand32(), rand32(), 1'b0, rand_reg(), 1'b1);
    mem_op(rv_ops_pkg::op_load, rv_ops_pkg::lsu_lw, 32'h40, 0, rand_reg(), 1'b0);

    random_mix(60);

    wait_idle();
    repeat (3) @(posedge clk);
    #1;
    finish_run();
  end

endmodule

/* sources.f */
rv_ops_pkg.sv
mem_pkg.sv
alu.sv
lsu.sv
mem_fsm.sv
wait_timer.sv
data_ram.sv
execute_stage.sv
exec_top.sv
exec_assertions.sv
exec_checker.sv
exec_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute slice simulation with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module exec_tb -o exec_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/exec_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" "$log"; then
  exit 0
fi
exit 1
